/* source/cvrp_consts.svh */
////////////////////////////////////////////////////////////////////////////
// CVRP genetic algorithm controller constants
// Node count, population size, transfer beats, run limits, data widths and
// the start values of the parent selector LFSRs
////////////////////////////////////////////////////////////////////////////

`ifndef CVRP_CONSTS_SVH
`define CVRP_CONSTS_SVH

// Processing nodes served by the controller
`define CVRP_NUM_NODES 4

// Individuals in the population and the width of an individual number
`define CVRP_POP_SIZE 40
`define CVRP_IND_W 6

// Width of a route length
`define CVRP_FIT_W 22

// Memory beats needed to move one individual
`define CVRP_NUM_BEATS 5

// Run limits and the width of the run count
`define CVRP_INIT_RUNS 6
`define CVRP_TOTAL_RUNS 20
`define CVRP_RUN_W 16

// Nonzero start values of the two selector LFSRs
`define CVRP_LFSR_SEED_A 6'h2B
`define CVRP_LFSR_SEED_B 6'h15

`endif

/* source/cvrp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// CVRP controller types
// Individual, fitness and run count words and the node exchange structs
////////////////////////////////////////////////////////////////////////////

`include "cvrp_consts.svh"

package cvrp_pkg;

	// Number of one individual within the population
	typedef logic [`CVRP_IND_W-1:0] individual_t;

	// Route length of a solution, smaller is better
	typedef logic [`CVRP_FIT_W-1:0] fitness_t;

	// Count of granted runs
	typedef logic [`CVRP_RUN_W-1:0] run_count_t;

	// Both parents handed to one node
	typedef struct packed {
		individual_t parent_1;
		individual_t parent_2;
	} parent_pair_t;

	// Controller to node, flags first and the parent pair last
	typedef struct packed {
		logic         init_mode;
		logic         start_parent_1;
		logic         finished_parent_1;
		logic         start_parent_2;
		logic         finished_parent_2;
		logic         wb_child_1;
		logic         wb_child_2;
		parent_pair_t parents;
	} node_ctrl_t;

	// Node to controller, better_slot and better_fitness ride with transmission_1
	typedef struct packed {
		logic     transmission_1;
		logic     transmission_2;
		logic     unchanged;
		logic     better_slot;
		fitness_t better_fitness;
	} node_rsp_t;

	// Best known fitness and the individual it belongs to
	typedef struct packed {
		fitness_t    fitness;
		individual_t address;
	} best_record_t;

endpackage

/* source/parent_selector.sv */
////////////////////////////////////////////////////////////////////////////
// Parent selector
// Two LFSRs propose a parent pair every cycle, the pair is approved when
// both parents differ and neither is held by any node
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module parent_selector (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [`CVRP_NUM_NODES-1:0]  grant_i,
	output cvrp_pkg::parent_pair_t      pair_o,
	output logic                        pair_ok_o
);

	// Two slots per node in the in-use table
	localparam int NUM_SLOTS = 2 * `CVRP_NUM_NODES;

	// Galois tap masks of two different maximal length polynomials
	localparam cvrp_pkg::individual_t TAPS_A = 6'h30;
	localparam cvrp_pkg::individual_t TAPS_B = 6'h21;

	// Population size as an individual number for the fold
	localparam cvrp_pkg::individual_t POP = cvrp_pkg::individual_t'(`CVRP_POP_SIZE);

	cvrp_pkg::individual_t lfsr_a;
	cvrp_pkg::individual_t lfsr_b;
	cvrp_pkg::individual_t prop_a;
	cvrp_pkg::individual_t prop_b;
	cvrp_pkg::individual_t in_use [NUM_SLOTS];
	logic                  a_free;
	logic                  b_free;
	logic                  hold_a;

	////////////////////////////////////////////////////////////////////////////
	// Random sources
	////////////////////////////////////////////////////////////////////////////

	// Both LFSRs shift right and feed the low bit back through the tap mask
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			lfsr_a <= `CVRP_LFSR_SEED_A;
			lfsr_b <= `CVRP_LFSR_SEED_B;
		end else begin
			// The first one waits while it only collides with the second
			if (!hold_a) begin
				lfsr_a <= {1'b0, lfsr_a[`CVRP_IND_W-1:1]} ^ (lfsr_a[0] ? TAPS_A : '0);
			end
			lfsr_b <= {1'b0, lfsr_b[`CVRP_IND_W-1:1]} ^ (lfsr_b[0] ? TAPS_B : '0);
		end
	end

	// Values past the last individual fold down by one population
	assign prop_a = (lfsr_a >= POP) ? (lfsr_a - POP) : lfsr_a;
	assign prop_b = (lfsr_b >= POP) ? (lfsr_b - POP) : lfsr_b;

	////////////////////////////////////////////////////////////////////////////
	// In-use check
	////////////////////////////////////////////////////////////////////////////

	// A proposal is free when no slot of the table holds it
	always_comb begin
		a_free = 1'b1;
		b_free = 1'b1;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (in_use[s] == prop_a) begin
				a_free = 1'b0;
			end
			if (in_use[s] == prop_b) begin
				b_free = 1'b0;
			end
		end
	end

	assign hold_a    = a_free && (prop_a == prop_b);
	assign pair_ok_o = a_free && b_free && (prop_a != prop_b);
	assign pair_o    = '{parent_1: prop_a, parent_2: prop_b};

	// The granted node keeps its pair in the table until its next grant
	// All ones is past the population, so an empty slot never matches
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				in_use[s] <= '1;
			end
		end else begin
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				if (grant_i[n]) begin
					in_use[2*n]     <= prop_a;
					in_use[2*n + 1] <= prop_b;
				end
			end
		end
	end

endmodule

/* source/run_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Run counter
// Counts granted runs and flags the init and total run limits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module run_counter (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [`CVRP_NUM_NODES-1:0]  grant_i,
	output logic                        init_done_o,
	output logic                        total_done_o
);

	// Run limits in the width of the counter
	localparam cvrp_pkg::run_count_t INIT_RUNS  = cvrp_pkg::run_count_t'(`CVRP_INIT_RUNS);
	localparam cvrp_pkg::run_count_t TOTAL_RUNS = cvrp_pkg::run_count_t'(`CVRP_TOTAL_RUNS);

	cvrp_pkg::run_count_t run_count;

	// At most one node is granted per cycle, so one step is enough
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			run_count <= '0;
		end else if (|grant_i) begin
			run_count <= run_count + 1'b1;
		end
	end

	// Both flags follow the count without delay
	assign init_done_o  = (run_count >= INIT_RUNS);
	assign total_done_o = (run_count >= TOTAL_RUNS);

endmodule

/* source/node_sequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Node sequencer
// Runs one node through request, both parent loads and the child writebacks,
// and reports the node's better fitness with its parent address
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module node_sequencer (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    enable_i,
	input  logic                    grant_i,
	input  logic                    init_mode_i,
	input  cvrp_pkg::parent_pair_t  pair_i,
	input  cvrp_pkg::node_rsp_t     rsp_i,
	output cvrp_pkg::node_ctrl_t    ctrl_o,
	output logic                    request_o,
	output logic                    idle_o,
	output cvrp_pkg::best_record_t  report_o,
	output logic                    report_valid_o
);

	// Beat counter covers the load beats plus the finished cycle
	localparam int BEAT_W = $clog2(`CVRP_NUM_BEATS + 1);
	localparam logic [BEAT_W-1:0] LOAD_END = BEAT_W'(`CVRP_NUM_BEATS);
	localparam logic [BEAT_W-1:0] WB_END   = BEAT_W'(`CVRP_NUM_BEATS - 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_REQUEST,
		S_LOAD_P1,
		S_LOAD_P2,
		S_WAIT_C1,
		S_WB_C1,
		S_WAIT_C2,
		S_WB_C2,
		S_FINAL
	} node_state_t;

	node_state_t             state;
	logic [BEAT_W-1:0]       beat;
	logic                    init_mode;
	cvrp_pkg::parent_pair_t  parents;

	////////////////////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= S_IDLE;
			beat      <= '0;
			init_mode <= 1'b0;
		end else begin
			// Every state change starts the next transfer at beat zero
			beat <= '0;
			case (state)
				S_IDLE: begin
					if (enable_i) begin
						state <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					// Runs may run out while the node still waits for a pair
					if (grant_i) begin
						state     <= S_LOAD_P1;
						init_mode <= init_mode_i;
					end else if (!enable_i) begin
						state <= S_IDLE;
					end
				end
				S_LOAD_P1: begin
					if (beat == LOAD_END) begin
						state <= S_LOAD_P2;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				S_LOAD_P2: begin
					if (beat == LOAD_END) begin
						state <= S_WAIT_C1;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				S_WAIT_C1: begin
					// An unchanged child needs no writeback
					if (rsp_i.transmission_1) begin
						state <= rsp_i.unchanged ? S_WAIT_C2 : S_WB_C1;
					end
				end
				S_WB_C1: begin
					if (beat == WB_END) begin
						state <= S_WAIT_C2;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				S_WAIT_C2: begin
					if (rsp_i.transmission_2) begin
						state <= rsp_i.unchanged ? S_FINAL : S_WB_C2;
					end
				end
				S_WB_C2: begin
					if (beat == WB_END) begin
						state <= S_FINAL;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// The pair stays with the node until its next grant
	always_ff @(posedge clk_i) begin
		if (grant_i) begin
			parents <= pair_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Start flags cover the load beats, finished marks the cycle after them
	always_comb begin
		ctrl_o                   = '0;
		ctrl_o.init_mode         = init_mode;
		ctrl_o.parents           = parents;
		ctrl_o.start_parent_1    = (state == S_LOAD_P1) && (beat != LOAD_END);
		ctrl_o.finished_parent_1 = (state == S_LOAD_P1) && (beat == LOAD_END);
		ctrl_o.start_parent_2    = (state == S_LOAD_P2) && (beat != LOAD_END);
		ctrl_o.finished_parent_2 = (state == S_LOAD_P2) && (beat == LOAD_END);
		ctrl_o.wb_child_1        = (state == S_WB_C1);
		ctrl_o.wb_child_2        = (state == S_WB_C2);
	end

	assign request_o = (state == S_REQUEST);
	assign idle_o    = (state == S_IDLE);

	// The better slot picks which parent the reported fitness belongs to
	assign report_valid_o   = (state == S_WAIT_C1) && rsp_i.transmission_1;
	assign report_o.fitness = rsp_i.better_fitness;
	assign report_o.address = rsp_i.better_slot ? parents.parent_2 : parents.parent_1;

endmodule

/* source/best_tracker.sv */
////////////////////////////////////////////////////////////////////////////
// Best tracker
// Keeps the best fitness reported by each node and finds the overall best
// in a scan of one node per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module best_tracker (
	input  logic                                         clk_i,
	input  logic                                         rst_i,
	input  cvrp_pkg::best_record_t [`CVRP_NUM_NODES-1:0] report_i,
	input  logic [`CVRP_NUM_NODES-1:0]                   report_valid_i,
	input  logic                                         scan_start_i,
	output cvrp_pkg::best_record_t                       best_o,
	output logic                                         scan_done_o
);

	localparam int IDX_W = $clog2(`CVRP_NUM_NODES);
	localparam logic [IDX_W-1:0] FIRST_IDX = IDX_W'(1);
	localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(`CVRP_NUM_NODES - 1);

	cvrp_pkg::best_record_t records [`CVRP_NUM_NODES];
	cvrp_pkg::best_record_t best;
	logic [IDX_W-1:0]       scan_idx;
	logic                   scanning;

	////////////////////////////////////////////////////////////////////////////
	// Per-node records
	////////////////////////////////////////////////////////////////////////////

	// A record starts at the worst fitness and only takes strictly better ones
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				records[n] <= '{fitness: '1, address: '0};
			end
		end else begin
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				if (report_valid_i[n] && (report_i[n].fitness < records[n].fitness)) begin
					records[n] <= report_i[n];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Final scan
	////////////////////////////////////////////////////////////////////////////

	// Node 0 is taken on the start cycle, the rest follow one per cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			scanning <= 1'b0;
			scan_idx <= '0;
		end else if (scan_start_i) begin
			scanning <= 1'b1;
			scan_idx <= FIRST_IDX;
		end else if (scanning) begin
			if (scan_idx == LAST_IDX) begin
				scanning <= 1'b0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end
	end

	// Only a strictly smaller fitness replaces, so the lowest index wins a tie
	always_ff @(posedge clk_i) begin
		if (scan_start_i) begin
			best <= records[0];
		end else if (scanning && (records[scan_idx].fitness < best.fitness)) begin
			best <= records[scan_idx];
		end
	end

	assign best_o      = best;
	assign scan_done_o = scanning && (scan_idx == LAST_IDX);

endmodule

/* source/run_controller.sv */
////////////////////////////////////////////////////////////////////////////
// Run controller
// Run-phase FSM and the fixed-priority grant of parent pairs to the nodes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module run_controller (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [`CVRP_NUM_NODES-1:0]  request_i,
	input  logic [`CVRP_NUM_NODES-1:0]  idle_i,
	input  logic                        pair_ok_i,
	input  logic                        init_done_i,
	input  logic                        total_done_i,
	input  logic                        scan_done_i,
	output logic [`CVRP_NUM_NODES-1:0]  grant_o,
	output logic                        enable_o,
	output logic                        init_mode_o,
	output logic                        scan_start_o,
	output logic                        init_phase_o,
	output logic                        done_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_INIT_RUNS,
		S_STD_RUNS,
		S_WAIT_END,
		S_EVALUATE,
		S_FINISHED
	} phase_t;

	phase_t state;
	logic   all_idle;

	assign all_idle = &idle_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:      state <= S_INIT_RUNS;
				S_INIT_RUNS: if (init_done_i) state <= S_STD_RUNS;
				S_STD_RUNS:  if (total_done_i) state <= S_WAIT_END;
				S_WAIT_END:  if (all_idle) state <= S_EVALUATE;
				S_EVALUATE:  if (scan_done_i) state <= S_FINISHED;
				default:     state <= S_FINISHED;
			endcase
		end
	end

	// Nodes stop asking for pairs in the same cycle the last run is counted
	assign enable_o     = ((state == S_INIT_RUNS) || (state == S_STD_RUNS)) && !total_done_i;
	assign init_phase_o = (state == S_INIT_RUNS) && !init_done_i;
	assign init_mode_o  = !init_done_i;
	assign scan_start_o = (state == S_WAIT_END) && all_idle;
	assign done_o       = (state == S_FINISHED);

	// The highest requesting node takes the approved pair
	always_comb begin
		grant_o = '0;
		if (enable_o && pair_ok_i) begin
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				if (request_i[n]) begin
					grant_o    = '0;
					grant_o[n] = 1'b1;
				end
			end
		end
	end

endmodule

/* source/ga_controller.sv */
////////////////////////////////////////////////////////////////////////////
// CVRP genetic algorithm controller
// Hands parent pairs to the processing nodes, sequences their transfers,
// counts the runs and finds the best solution at the end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module ga_controller (
	input  logic                                         clk_i,
	input  logic                                         rst_i,
	input  cvrp_pkg::node_rsp_t [`CVRP_NUM_NODES-1:0]    node_rsp_i,
	output cvrp_pkg::node_ctrl_t [`CVRP_NUM_NODES-1:0]   node_ctrl_o,
	output logic                                         init_phase_o,
	output logic                                         done_o,
	output cvrp_pkg::best_record_t                       best_o
);

	cvrp_pkg::parent_pair_t                       pair;
	cvrp_pkg::best_record_t [`CVRP_NUM_NODES-1:0] report;
	logic [`CVRP_NUM_NODES-1:0]                   report_valid;
	logic [`CVRP_NUM_NODES-1:0]                   grant;
	logic [`CVRP_NUM_NODES-1:0]                   request;
	logic [`CVRP_NUM_NODES-1:0]                   idle;
	logic                                         pair_ok;
	logic                                         enable;
	logic                                         init_mode;
	logic                                         init_done;
	logic                                         total_done;
	logic                                         scan_start;
	logic                                         scan_done;

	parent_selector u_parent_selector (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.grant_i   (grant),
		.pair_o    (pair),
		.pair_ok_o (pair_ok)
	);

	run_counter u_run_counter (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.grant_i      (grant),
		.init_done_o  (init_done),
		.total_done_o (total_done)
	);

	run_controller u_run_controller (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.request_i    (request),
		.idle_i       (idle),
		.pair_ok_i    (pair_ok),
		.init_done_i  (init_done),
		.total_done_i (total_done),
		.scan_done_i  (scan_done),
		.grant_o      (grant),
		.enable_o     (enable),
		.init_mode_o  (init_mode),
		.scan_start_o (scan_start),
		.init_phase_o (init_phase_o),
		.done_o       (done_o)
	);

	best_tracker u_best_tracker (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.report_i       (report),
		.report_valid_i (report_valid),
		.scan_start_i   (scan_start),
		.best_o         (best_o),
		.scan_done_o    (scan_done)
	);

	// One transfer sequencer per processing node
	for (genvar n = 0; n < `CVRP_NUM_NODES; n++) begin : g_node
		node_sequencer u_node_sequencer (
			.clk_i          (clk_i),
			.rst_i          (rst_i),
			.enable_i       (enable),
			.grant_i        (grant[n]),
			.init_mode_i    (init_mode),
			.pair_i         (pair),
			.rsp_i          (node_rsp_i[n]),
			.ctrl_o         (node_ctrl_o[n]),
			.request_o      (request[n]),
			.idle_o         (idle[n]),
			.report_o       (report[n]),
			.report_valid_o (report_valid[n])
		);
	end

endmodule

/* test/ga_controller_asserts.sv */
////////////////////////////////////////////////////////////////////////////
// CVRP controller assertions
// Reset values, the init phase, parent pairs, transfer beats and
// writebacks seen on the ports of the controller top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module ga_controller_asserts (
	input logic                                        clk_i,
	input logic                                        rst_i,
	input cvrp_pkg::node_rsp_t  [`CVRP_NUM_NODES-1:0]  node_rsp_i,
	input cvrp_pkg::node_ctrl_t [`CVRP_NUM_NODES-1:0]  node_ctrl_o,
	input logic                                        init_phase_o,
	input logic                                        done_o
);

	// Number of failed assertions so far
	int fail_count = 0;

	// All control flags of one node without the parent pair
	function automatic logic [6:0] flags_of(cvrp_pkg::node_ctrl_t c);
		return {c.init_mode, c.start_parent_1, c.finished_parent_1, c.start_parent_2,
			c.finished_parent_2, c.wb_child_1, c.wb_child_2};
	endfunction

	// True when another node with a transfer in progress holds one of our parents
	function automatic logic pair_clash(cvrp_pkg::node_ctrl_t [`CVRP_NUM_NODES-1:0] ctrl,
		int self);
		logic clash;
		clash = 1'b0;
		for (int m = 0; m < `CVRP_NUM_NODES; m++) begin
			if ((m != self) && (flags_of(ctrl[m]) & 7'h3F) != '0) begin
				if ((ctrl[self].parents.parent_1 == ctrl[m].parents.parent_1) ||
					(ctrl[self].parents.parent_1 == ctrl[m].parents.parent_2) ||
					(ctrl[self].parents.parent_2 == ctrl[m].parents.parent_1) ||
					(ctrl[self].parents.parent_2 == ctrl[m].parents.parent_2)) begin
					clash = 1'b1;
				end
			end
		end
		return clash;
	endfunction

	// The phase outputs are low after reset and done stays high once set
	a_reset_phase: assert property (@(posedge clk_i) rst_i |=> !init_phase_o && !done_o)
		else begin
			fail_count++;
			$error("Phase outputs not low after reset");
		end
	a_done_held: assert property (@(posedge clk_i) disable iff (rst_i) done_o |=> done_o)
		else begin
			fail_count++;
			$error("done_o dropped after rising");
		end

	////////////////////////////////////////////////////////////////////////////
	// Per-node checks
	////////////////////////////////////////////////////////////////////////////

	for (genvar n = 0; n < `CVRP_NUM_NODES; n++) begin : g_node
		a_reset_flags: assert property (@(posedge clk_i)
			rst_i |=> flags_of(node_ctrl_o[n]) == '0)
			else begin
				fail_count++;
				$error("Node %0d flags not low after reset", n);
			end

		// A new pair is in range, has two different parents and is held by no busy node
		a_pair: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].start_parent_1) |->
				(node_ctrl_o[n].parents.parent_1 < `CVRP_POP_SIZE) &&
				(node_ctrl_o[n].parents.parent_2 < `CVRP_POP_SIZE) &&
				(node_ctrl_o[n].parents.parent_1 != node_ctrl_o[n].parents.parent_2) &&
				!pair_clash(node_ctrl_o, n))
			else begin
				fail_count++;
				$error("Node %0d got an invalid parent pair", n);
			end

		// A grant made in the init phase carries init_mode and a later one does not
		a_init_mode: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].start_parent_1) |->
				(node_ctrl_o[n].init_mode == $past(init_phase_o)))
			else begin
				fail_count++;
				$error("Node %0d init_mode disagrees with the init phase", n);
			end

		// Each load lasts the beat count and ends in a one-cycle finished pulse
		a_load_1: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].start_parent_1) |->
				node_ctrl_o[n].start_parent_1 [*`CVRP_NUM_BEATS] ##1
				(node_ctrl_o[n].finished_parent_1 && !node_ctrl_o[n].start_parent_1) ##1
				(!node_ctrl_o[n].finished_parent_1 && node_ctrl_o[n].start_parent_2))
			else begin
				fail_count++;
				$error("Node %0d parent 1 load timing wrong", n);
			end
		a_load_2: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].start_parent_2) |->
				node_ctrl_o[n].start_parent_2 [*`CVRP_NUM_BEATS] ##1
				(node_ctrl_o[n].finished_parent_2 && !node_ctrl_o[n].start_parent_2) ##1
				!node_ctrl_o[n].finished_parent_2)
			else begin
				fail_count++;
				$error("Node %0d parent 2 load timing wrong", n);
			end

		// A changed child is written back for the beat count and an unchanged one never
		a_wb_1_len: assert property (@(posedge clk_i) disable iff (rst_i)
			(node_rsp_i[n].transmission_1 && !node_rsp_i[n].unchanged) |=>
				node_ctrl_o[n].wb_child_1 [*`CVRP_NUM_BEATS] ##1 !node_ctrl_o[n].wb_child_1)
			else begin
				fail_count++;
				$error("Node %0d child 1 writeback length wrong", n);
			end
		a_wb_1_cause: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].wb_child_1) |->
				$past(node_rsp_i[n].transmission_1 && !node_rsp_i[n].unchanged))
			else begin
				fail_count++;
				$error("Node %0d child 1 writeback without cause", n);
			end
		a_wb_2_len: assert property (@(posedge clk_i) disable iff (rst_i)
			(node_rsp_i[n].transmission_2 && !node_rsp_i[n].unchanged) |=>
				node_ctrl_o[n].wb_child_2 [*`CVRP_NUM_BEATS] ##1 !node_ctrl_o[n].wb_child_2)
			else begin
				fail_count++;
				$error("Node %0d child 2 writeback length wrong", n);
			end
		a_wb_2_cause: assert property (@(posedge clk_i) disable iff (rst_i)
			$rose(node_ctrl_o[n].wb_child_2) |->
				$past(node_rsp_i[n].transmission_2 && !node_rsp_i[n].unchanged))
			else begin
				fail_count++;
				$error("Node %0d child 2 writeback without cause", n);
			end
	end

endmodule

bind ga_controller ga_controller_asserts u_asserts (.*);

/* test/ga_controller_tb.sv */
////////////////////////////////////////////////////////////////////////////
// CVRP controller testbench
// Node engine models answer each transfer with random children, and a
// scoreboard checks the run counts and the final best solution
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "cvrp_consts.svh"

module ga_controller_tb;

	localparam int TIMEOUT = 20000;

	logic                                       clk;
	logic                                       rst;
	cvrp_pkg::node_rsp_t  [`CVRP_NUM_NODES-1:0] node_rsp;
	cvrp_pkg::node_ctrl_t [`CVRP_NUM_NODES-1:0] node_ctrl;
	logic                                       init_phase;
	logic                                       done;
	cvrp_pkg::best_record_t                     best;

	logic [31:0]            lcg_state = 32'd70740;
	int                     errors = 0;
	int                     grants = 0;
	int                     init_grants = 0;
	cvrp_pkg::best_record_t node_best [`CVRP_NUM_NODES];
	int                     phase [`CVRP_NUM_NODES];
	int                     wait_cnt [`CVRP_NUM_NODES];
	logic                   prev_sp1 [`CVRP_NUM_NODES];

	ga_controller UUT (
		.clk_i        (clk),
		.rst_i        (rst),
		.node_rsp_i   (node_rsp),
		.node_ctrl_o  (node_ctrl),
		.init_phase_o (init_phase),
		.done_o       (done),
		.best_o       (best)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Engine delay of 1 to 8 cycles from the top bits of the generator
	function automatic int random_delay();
		logic [31:0] r;
		r = next_random();
		return 1 + int'(r[31:29]);
	endfunction

	// A node keeps only a strictly smaller fitness
	task automatic record_report(input int n, input cvrp_pkg::fitness_t fit,
		input cvrp_pkg::individual_t addr);
		if (fit < node_best[n].fitness) begin
			node_best[n] = '{fitness: fit, address: addr};
		end
	endtask

	task automatic compare_value(input string name, input longint expected,
		input longint actual);
		if (expected != actual) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Node engine models
	////////////////////////////////////////////////////////////////////////////

	// Phase 0 waits for parent 2 and phase 1 counts down to child 1
	// Phases 2 and 3 follow writeback 1 and phase 4 counts down to child 2
	initial begin : node_models
		logic [31:0] r;
		logic [31:0] s;
		node_rsp = '0;
		for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
			phase[n]     = 0;
			wait_cnt[n]  = 0;
			prev_sp1[n]  = 1'b0;
			node_best[n] = '{fitness: '1, address: '0};
		end
		forever begin
			@(negedge clk);
			node_rsp = '0;
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				// The rise of start_parent_1 marks one granted run
				if (node_ctrl[n].start_parent_1 && !prev_sp1[n]) begin
					grants++;
					if (node_ctrl[n].init_mode) begin
						init_grants++;
					end
				end
				prev_sp1[n] = node_ctrl[n].start_parent_1;
				case (phase[n])
					0: begin
						if (node_ctrl[n].finished_parent_2) begin
							wait_cnt[n] = random_delay();
							phase[n]    = 1;
						end
					end
					1: begin
						wait_cnt[n]--;
						if (wait_cnt[n] == 0) begin
							r = next_random();
							s = next_random();
							node_rsp[n].transmission_1 = 1'b1;
							node_rsp[n].better_fitness = r[31:10];
							node_rsp[n].better_slot    = s[31];
							node_rsp[n].unchanged      = s[30];
							record_report(n, r[31:10], s[31] ? node_ctrl[n].parents.parent_2
								: node_ctrl[n].parents.parent_1);
							wait_cnt[n] = random_delay();
							phase[n]    = s[30] ? 4 : 2;
						end
					end
					2: begin
						if (node_ctrl[n].wb_child_1) begin
							phase[n] = 3;
						end
					end
					3: begin
						if (!node_ctrl[n].wb_child_1) begin
							wait_cnt[n] = random_delay();
							phase[n]    = 4;
						end
					end
					default: begin
						wait_cnt[n]--;
						if (wait_cnt[n] == 0) begin
							s = next_random();
							node_rsp[n].transmission_2 = 1'b1;
							node_rsp[n].unchanged      = s[31];
							phase[n]                   = 0;
						end
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		int                     cycles;
		int                     assert_fails;
		cvrp_pkg::best_record_t expected;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cycles = 0;
		while (!done && (cycles < TIMEOUT)) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: done_o did not rise within %0d cycles", TIMEOUT);
			errors++;
		end else begin
			// The done level is watched for a few more cycles while it must stay high
			repeat (4) @(negedge clk);
			// Lowest node index wins a tie in the final minimum
			expected = node_best[0];
			for (int n = 1; n < `CVRP_NUM_NODES; n++) begin
				if (node_best[n].fitness < expected.fitness) begin
					expected = node_best[n];
				end
			end
			compare_value("init_grants", `CVRP_INIT_RUNS, init_grants);
			compare_value("total_grants", `CVRP_TOTAL_RUNS, grants);
			compare_value("best_fitness", expected.fitness, best.fitness);
			compare_value("best_address", expected.address, best.address);
		end
		assert_fails = UUT.u_asserts.fail_count;
		$display("Errors: %0d check, %0d assertion", errors, assert_fails);
		if ((errors == 0) && (assert_fails == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+source
source/cvrp_pkg.sv
source/parent_selector.sv
source/run_counter.sv
source/node_sequencer.sv
source/best_tracker.sv
source/run_controller.sv
source/ga_controller.sv
test/ga_controller_asserts.sv
test/ga_controller_tb.sv
